// ==== noc_pkg.sv ====
package noc_pkg;

   // Flit and buffer sizing
   localparam int DATA_WIDTH = 32;   // Payload bits per flit
   localparam int BUF_DEPTH  = 8;    // Flits per packet buffer
   localparam int SIZE_WIDTH = $clog2(BUF_DEPTH + 1);   // Holds 0 to BUF_DEPTH

   // Merge width
   localparam int N_SRC     = 2;     // Input ports into the arbiter
   localparam int SRC_WIDTH = (N_SRC > 1) ? $clog2(N_SRC) : 1;   // Grant index bits

   // Position of a flit inside its packet
   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,   // Middle flit
      FLIT_HEADER  = 2'b01,   // Opens a multi-flit packet
      FLIT_LAST    = 2'b10,   // Closes a multi-flit packet
      FLIT_SINGLE  = 2'b11    // Whole packet in one flit
   } flit_type_t;

   // Type code sits above the payload, 34 bits in all
   typedef struct packed {
      flit_type_t             ftype;
      logic [DATA_WIDTH-1:0]  data;
   } flit_t;

   // Flit ends a packet
   function automatic logic is_last(flit_type_t t);
      return (t == FLIT_LAST) || (t == FLIT_SINGLE);
   endfunction

   // Flit opens a packet
   function automatic logic is_first(flit_type_t t);
      return (t == FLIT_HEADER) || (t == FLIT_SINGLE);
   endfunction

endpackage

// ==== noc_packet_buffer.sv ====
`timescale 1ns/100ps

// Flit FIFO that releases its head only once a full packet is inside
module noc_packet_buffer import noc_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,

   // Upstream flit link
   input  flit_t                  in_flit,
   input  logic                   in_valid,
   output logic                   in_ready,

   // Downstream flit link towards the arbiter
   output flit_t                  out_flit,
   output logic                   out_valid,
   input  logic                   out_ready,
   output logic [SIZE_WIDTH-1:0]  out_size
);

   // One-hot fill level, bit k set means k flits stored
   logic [BUF_DEPTH:0]    wr_ptr;

   // Shift storage, slot 0 is the head
   flit_t                 mem       [BUF_DEPTH];
   logic [BUF_DEPTH-1:0]  last_mark;   // Slot holds a last or single flit

   // Contents one slot up, shifted down on pop
   flit_t                 mem_up    [BUF_DEPTH];
   logic [BUF_DEPTH-1:0]  last_up;

   logic [BUF_DEPTH-1:0]  occupied;    // Slot holds a stored flit
   logic [BUF_DEPTH-1:0]  pkt_end;     // Stored packet ends in this slot
   logic                  in_last;
   logic                  push;
   logic                  pop;

   assign in_last = is_last(in_flit.ftype);

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   assign in_ready = ~wr_ptr[BUF_DEPTH];   // Low only when full

   // Thermometer of used slots from the one-hot level
   always_comb begin
      occupied[BUF_DEPTH-1] = wr_ptr[BUF_DEPTH];
      for (int i = BUF_DEPTH - 2; i >= 0; i--) begin
         occupied[i] = occupied[i+1] | wr_ptr[i+1];
      end
   end

   assign pkt_end = last_mark & occupied;   // Stale marks masked off

   assign out_valid = |pkt_end;   // At least one whole packet stored
   assign out_flit  = mem[0];

   // Length of the head packet, first end mark wins
   always_comb begin
      logic found;
      found    = 1'b0;
      out_size = '0;
      for (int i = 0; i < BUF_DEPTH; i++) begin
         if (!found && pkt_end[i]) begin
            out_size = SIZE_WIDTH'(i + 1);
            found    = 1'b1;
         end
      end
   end

   // Shift source per slot
   always_comb begin
      for (int i = 0; i < BUF_DEPTH - 1; i++) begin
         mem_up[i]  = mem[i+1];
         last_up[i] = last_mark[i+1];
      end
      mem_up[BUF_DEPTH-1]  = in_flit;   // Top slot is refilled only by a push
      last_up[BUF_DEPTH-1] = 1'b0;
   end

   // Fill level
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= {{BUF_DEPTH{1'b0}}, 1'b1};   // Empty
      end else if (push && !pop) begin
         wr_ptr <= wr_ptr << 1;
      end else if (pop && !push) begin
         wr_ptr <= wr_ptr >> 1;
      end
   end

   // Storage shifts towards the head on pop, push lands at the fill level
   always_ff @(posedge clk) begin
      for (int i = 0; i < BUF_DEPTH; i++) begin
         if (pop && push && wr_ptr[i+1]) begin
            mem[i]       <= in_flit;   // Lands one below the old level
            last_mark[i] <= in_last;
         end else if (pop) begin
            mem[i]       <= mem_up[i];
            last_mark[i] <= last_up[i];
         end else if (push && wr_ptr[i]) begin
            mem[i]       <= in_flit;
            last_mark[i] <= in_last;
         end
      end
   end

   // Level stays one-hot, so nothing went in while full
   a_no_overflow: assert property (
      @(posedge clk) disable iff (rst)
      $onehot(wr_ptr)
   ) else $error("packet buffer fill level lost, push while full");

   // Offered head flit holds until taken
   a_head_stable: assert property (
      @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_flit)
   ) else $error("packet buffer head changed under back-pressure");

endmodule

// ==== noc_packet_arbiter.sv ====
`timescale 1ns/100ps

// Round-robin merge of whole packets from N_SRC buffers onto one link
module noc_packet_arbiter import noc_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,

   // Packet sources
   input  flit_t                  src_flit  [N_SRC],
   input  logic [N_SRC-1:0]       src_valid,
   input  logic [SIZE_WIDTH-1:0]  src_size  [N_SRC],
   output logic [N_SRC-1:0]       src_ready,

   // Shared output link
   output flit_t                  out_flit,
   output logic                   out_valid,
   output logic [SIZE_WIDTH-1:0]  out_size,
   input  logic                   out_ready
);

   logic                  locked;    // Grant held inside a packet or a stalled offer
   logic [SRC_WIDTH-1:0]  grant;     // Held source
   logic [SRC_WIDTH-1:0]  rr_ptr;    // Source preferred next
   logic [SRC_WIDTH-1:0]  pick;      // Round-robin choice while free
   logic [SRC_WIDTH-1:0]  cur;       // Source on the link this cycle
   logic                  xfer;
   logic                  pkt_done;

   // First valid source at or after the pointer
   always_comb begin
      int   idx;
      logic found;
      found = 1'b0;
      pick  = rr_ptr;
      for (int k = 0; k < N_SRC; k++) begin
         idx = (int'(rr_ptr) + k) % N_SRC;
         if (!found && src_valid[idx]) begin
            pick  = SRC_WIDTH'(idx);
            found = 1'b1;
         end
      end
   end

   assign cur = locked ? grant : pick;

   // Data path follows the current source with no register
   assign out_flit  = src_flit[cur];
   assign out_size  = src_size[cur];
   assign out_valid = src_valid[cur];

   // Ready goes back to the current source only
   always_comb begin
      src_ready = '0;
      src_ready[cur] = out_ready;
   end

   assign xfer     = out_valid & out_ready;
   assign pkt_done = xfer & is_last(out_flit.ftype);   // Packet leaves on this edge

   // Lock, grant and pointer
   always_ff @(posedge clk) begin
      if (rst) begin
         locked <= 1'b0;
         grant  <= '0;
         rr_ptr <= '0;
      end else begin
         if (pkt_done) begin
            locked <= 1'b0;
            // Next turn goes to the source after this one
            rr_ptr <= (cur == SRC_WIDTH'(N_SRC - 1)) ? '0 : cur + 1'b1;
         end else if (out_valid) begin
            locked <= 1'b1;   // Header sent or offer stalled
         end
         if (!locked && out_valid) begin
            grant <= pick;
         end
      end
   end

   // Buffers must present packet starts whenever the link is free
   a_first_when_free: assert property (
      @(posedge clk) disable iff (rst)
      !locked && xfer |-> is_first(out_flit.ftype)
   ) else $error("arbiter passed a middle flit while unlocked");

   // Source on the link holds until its packet leaves, stalls included
   a_grant_held: assert property (
      @(posedge clk) disable iff (rst)
      out_valid && !pkt_done |=> cur == $past(cur)
   ) else $error("arbiter grant moved while locked");

endmodule

// ==== noc_merge_port.sv ====
`timescale 1ns/100ps

// Two packet buffers merged onto one router output link
module noc_merge_port import noc_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,

   // Input port 0
   input  flit_t                  in0_flit,
   input  logic                   in0_valid,
   output logic                   in0_ready,

   // Input port 1
   input  flit_t                  in1_flit,
   input  logic                   in1_valid,
   output logic                   in1_ready,

   // Output link
   output flit_t                  out_flit,
   output logic                   out_valid,
   output logic [SIZE_WIDTH-1:0]  out_size,
   input  logic                   out_ready
);

   // Buffer to arbiter links
   flit_t                  buf_flit  [N_SRC];
   logic [N_SRC-1:0]       buf_valid;
   logic [N_SRC-1:0]       buf_ready;
   logic [SIZE_WIDTH-1:0]  buf_size  [N_SRC];

   noc_packet_buffer u_buf0 (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in0_flit),
      .in_valid  (in0_valid),
      .in_ready  (in0_ready),
      .out_flit  (buf_flit[0]),
      .out_valid (buf_valid[0]),
      .out_ready (buf_ready[0]),
      .out_size  (buf_size[0])
   );

   noc_packet_buffer u_buf1 (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in1_flit),
      .in_valid  (in1_valid),
      .in_ready  (in1_ready),
      .out_flit  (buf_flit[1]),
      .out_valid (buf_valid[1]),
      .out_ready (buf_ready[1]),
      .out_size  (buf_size[1])
   );

   noc_packet_arbiter u_arb (
      .clk       (clk),
      .rst       (rst),
      .src_flit  (buf_flit),
      .src_valid (buf_valid),
      .src_size  (buf_size),
      .src_ready (buf_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_size  (out_size),
      .out_ready (out_ready)
   );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

// Free-running clock and power-on reset for the testbench
module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;   // 20 ns period
      end
   end

   // Two full clock periods of reset, released on a falling edge
   initial begin
      rst = 1'b1;
      #40 rst = 1'b0;
   end

endmodule

// ==== tb_merge_port.sv ====
`timescale 1ns/100ps

// Merge port testbench, random traffic on both inputs against a queue model
module tb_merge_port import noc_pkg::*; ();

   localparam int TIMEOUT = 2000;   // Cycles allowed for any single wait

   logic                   clk;
   logic                   rst;
   flit_t                  in_flit   [N_SRC];
   logic [N_SRC-1:0]       in_valid;
   wire  [N_SRC-1:0]       in_ready;
   flit_t                  out_flit;
   logic                   out_valid;
   logic [SIZE_WIDTH-1:0]  out_size;
   logic                   out_ready;

   // Reference model
   flit_t                  flit_q    [N_SRC][$];   // Flits inside the DUT per source
   int                     size_q    [N_SRC][$];   // Lengths of closed packets
   int                     in_len    [N_SRC];      // Flits of the open input packet
   int                     occ       [N_SRC];      // Buffer fill per port
   flit_t                  exp_head  [N_SRC];
   logic                   head_ok   [N_SRC];
   logic [SIZE_WIDTH-1:0]  size_head [N_SRC];
   int                     pend;        // Closed packets not yet fully out
   logic                   in_pkt;      // Output is inside a multi-flit packet
   logic                   pkt_src;
   logic                   rr_armed;    // Other port was waiting as a packet ended
   logic                   rr_src;
   logic                   stalled;     // Offer held back on the last edge
   flit_t                  prev_flit;

   logic                   out_src;
   logic                   out_xfer;
   logic                   last_in;
   flit_t                  exp_flit;
   logic                   exp_ok;
   logic [SIZE_WIDTH-1:0]  exp_size;
   logic [N_SRC-1:0]       exp_ready;

   int                     errors         = 0;
   int                     tests_run      = 0;
   int                     tests_failed   = 0;
   int                     test_err_start = 0;
   int                     senders_done   = 0;
   int                     pkt_num [N_SRC] = '{0, 0};
   int unsigned            lcg_state      = 93;

   tb_clock_gen u_clk (
      .clk (clk),
      .rst (rst)
   );

   noc_merge_port dut (
      .clk       (clk),
      .rst       (rst),
      .in0_flit  (in_flit[0]),
      .in0_valid (in_valid[0]),
      .in0_ready (in_ready[0]),
      .in1_flit  (in_flit[1]),
      .in1_valid (in_valid[1]),
      .in1_ready (in_ready[1]),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_size  (out_size),
      .out_ready (out_ready)
   );

   assign out_src  = out_flit.data[24];   // Source number sits in the top byte
   assign out_xfer = out_valid && out_ready;
   assign exp_flit = exp_head[out_src];
   assign exp_ok   = head_ok[out_src];
   assign exp_size = size_head[out_src];

   always_comb begin
      last_in = 1'b0;
      for (int s = 0; s < N_SRC; s++) begin
         exp_ready[s] = occ[s] < BUF_DEPTH;   // Ready drops only when full
         last_in      = last_in | (in_valid[s] && in_ready[s] && is_last(in_flit[s].ftype));
      end
   end

   // Model follows both sides of the DUT on every edge
   always @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < N_SRC; s++) begin
            flit_q[s].delete();
            size_q[s].delete();
            in_len[s] = 0;
            occ[s]    = 0;
         end
         pend     = 0;
         in_pkt   = 1'b0;
         pkt_src  = 1'b0;
         rr_armed = 1'b0;
         rr_src   = 1'b0;
         stalled  = 1'b0;
      end else begin
         for (int s = 0; s < N_SRC; s++) begin
            if (in_valid[s] && in_ready[s]) begin
               flit_q[s].push_back(in_flit[s]);
               occ[s]++;
               in_len[s]++;
               if (is_last(in_flit[s].ftype)) begin   // Packet closed, length known
                  size_q[s].push_back(in_len[s]);
                  in_len[s] = 0;
                  pend++;
               end
            end
         end
         if (out_xfer) begin
            if (flit_q[out_src].size() > 0) begin
               void'(flit_q[out_src].pop_front());
            end
            occ[out_src]--;
            if (is_first(out_flit.ftype)) begin
               if (size_q[out_src].size() > 0) begin
                  void'(size_q[out_src].pop_front());
               end
               rr_armed = 1'b0;
            end
            if (is_last(out_flit.ftype)) begin
               in_pkt   = 1'b0;
               pend--;
               rr_armed = size_q[~out_src].size() > 0;   // Other port holds a whole packet
               rr_src   = ~out_src;
            end else begin
               in_pkt  = 1'b1;
               pkt_src = out_src;
            end
         end
         stalled   = out_valid && !out_ready;
         prev_flit = out_flit;
      end
      for (int s = 0; s < N_SRC; s++) begin
         head_ok[s]   = flit_q[s].size() > 0;
         exp_head[s]  = head_ok[s] ? flit_q[s][0] : '0;
         size_head[s] = (size_q[s].size() > 0) ? SIZE_WIDTH'(size_q[s][0]) : '0;
      end
   end

   // Nothing offered while only partial packets are inside
   a_partial_held: assert property (@(posedge clk) disable iff (rst)
      pend == 0 |-> !out_valid)
      else report_mismatch("out_valid", 0, $sampled(out_valid));

   // One cycle from last flit in to out_valid on an idle port
   a_release: assert property (@(posedge clk) disable iff (rst)
      last_in && pend == 0 |=> out_valid)
      else report_mismatch("out_valid", 1, $sampled(out_valid));

   a_order: assert property (@(posedge clk) disable iff (rst)
      out_xfer |-> exp_ok && out_flit == exp_flit)
      else report_mismatch("out_flit", $sampled(exp_flit), $sampled(out_flit));

   a_same_src: assert property (@(posedge clk) disable iff (rst)
      out_xfer && in_pkt |-> out_src == pkt_src)
      else report_mismatch("out_flit source", $sampled(pkt_src), $sampled(out_src));

   // A fresh packet opens with a header or single flit
   a_pkt_start: assert property (@(posedge clk) disable iff (rst)
      out_xfer && !in_pkt |-> is_first(out_flit.ftype))
      else report_mismatch("out_flit.ftype", FLIT_HEADER, $sampled(out_flit.ftype));

   a_round_robin: assert property (@(posedge clk) disable iff (rst)
      out_xfer && !in_pkt && rr_armed |-> out_src == rr_src)
      else report_mismatch("out_flit source", $sampled(rr_src), $sampled(out_src));

   a_stall_valid: assert property (@(posedge clk) disable iff (rst)
      stalled |-> out_valid)
      else report_mismatch("out_valid", 1, $sampled(out_valid));

   a_stall_flit: assert property (@(posedge clk) disable iff (rst)
      stalled |-> out_flit == prev_flit)
      else report_mismatch("out_flit", $sampled(prev_flit), $sampled(out_flit));

   a_size: assert property (@(posedge clk) disable iff (rst)
      out_xfer && is_first(out_flit.ftype) |-> out_size == exp_size)
      else report_mismatch("out_size", $sampled(exp_size), $sampled(out_size));

   a_in_ready: assert property (@(posedge clk) disable iff (rst)
      in_ready == exp_ready)
      else report_mismatch("in_ready", $sampled(exp_ready), $sampled(in_ready));

   // LCG step, result below n
   function automatic int rand_below(input int n);
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'((lcg_state >> 16) % n);
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] expv,
                                  input logic [63:0] actv);
      errors++;
      $display("** Error %0t ns: %s expected %h actual %h", $time, name, expv, actv);
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      $display("Finished with errors");
      $finish;
   endtask

   task automatic wait_reset_done();
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > TIMEOUT) begin
            fail_timeout("reset release");
         end
      end while (rst);
   endtask

   // One packet on port s, random idle cycles before each flit
   task automatic send_packet(input int s, input int len, input int max_gap);
      flit_t f;
      int    waited;
      for (int i = 0; i < len; i++) begin
         repeat (rand_below(max_gap + 1)) begin
            @(posedge clk);
            #2;
         end
         f.ftype = (len == 1)     ? FLIT_SINGLE :
                   (i == 0)       ? FLIT_HEADER :
                   (i == len - 1) ? FLIT_LAST   : FLIT_PAYLOAD;
         f.data      = {8'(s), 16'(pkt_num[s]), 8'(i)};   // Source, packet, index
         in_flit[s]  = f;
         in_valid[s] = 1'b1;
         waited      = 0;
         do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
               fail_timeout($sformatf("port %0d to accept a flit", s));
            end
         end while (!in_ready[s]);
         #2;
         in_valid[s] = 1'b0;
      end
      pkt_num[s]++;
   endtask

   task automatic send_burst(input int s, input int npkt, input int max_gap);
      for (int p = 0; p < npkt; p++) begin
         send_packet(s, 1 + rand_below(BUF_DEPTH), max_gap);
      end
      senders_done++;
   endtask

   // Random out_ready until both senders are through
   task automatic drive_stalls();
      int waited;
      waited = 0;
      while (senders_done < N_SRC) begin
         @(posedge clk);
         #2;
         out_ready = rand_below(4) != 0;   // Stalled about a quarter of the time
         waited++;
         if (waited > 10 * TIMEOUT) begin
            fail_timeout("both senders to finish");
         end
      end
      out_ready = 1'b1;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (pend != 0 || flit_q[0].size() != 0 || flit_q[1].size() != 0) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > TIMEOUT) begin
            fail_timeout("the output to drain");
         end
      end
   endtask

   task automatic wait_full(input int s);
      int waited;
      waited = 0;
      while (in_ready[s]) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > TIMEOUT) begin
            $display("Port %0d never reported full with the output stalled", s);
            errors++;
            break;
         end
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_err_start) begin
         tests_failed++;
      end
      $display("test %-13s %0d errors", name, errors - test_err_start);
      test_err_start = errors;
   endtask

   initial begin
      in_valid   = '0;
      in_flit[0] = '0;
      in_flit[1] = '0;
      out_ready  = 1'b0;
      wait_reset_done();

      // Slow packet on one port, other port idle
      out_ready = 1'b1;
      send_packet(0, 4, 3);
      wait_drain();
      end_test("release");

      // Both ports busy, output always ready
      fork
         send_burst(0, 12, 1);
         send_burst(1, 12, 1);
      join
      wait_drain();
      end_test("order");

      senders_done = 0;
      fork
         send_burst(0, 12, 2);
         send_burst(1, 12, 2);
         drive_stalls();
      join
      wait_drain();
      end_test("backpressure");

      // Port 0 filled to BUF_DEPTH behind a held output
      out_ready = 1'b0;
      send_packet(0, 5, 0);
      send_packet(0, 3, 0);
      wait_full(0);
      out_ready = 1'b1;
      wait_drain();
      end_test("full");

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
noc_pkg.sv
noc_packet_buffer.sv
noc_packet_arbiter.sv
noc_merge_port.sv
tb_clock_gen.sv
tb_merge_port.sv

// ==== Bender.yml ====
package:
  name: noc_merge_port

sources:
  - noc_pkg.sv
  - noc_packet_buffer.sv
  - noc_packet_arbiter.sv
  - noc_merge_port.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_merge_port.sv
